// ==== design/afu_settings.svh ====
// Widths, queue depth and read limit for the accelerator shell
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// Host word address and data widths
`define AFU_ADDR_WIDTH 16
`define AFU_DATA_WIDTH 64

// MMIO word offset width
`define AFU_MMIO_ADDR_WIDTH 8

// Entries per request queue and the occupancy count width (must hold the depth)
`define AFU_FIFO_DEPTH 8
`define AFU_COUNT_WIDTH 4

// Kernel reads in flight and the width of their counter
`define AFU_MAX_READS 4
`define AFU_READS_WIDTH 3

`endif

// ==== design/afu_pkg.sv ====
// Shared types of the shell: memory request, MMIO strobes, kernel control and status
// Register offsets of the MMIO block
`default_nettype none
`include "afu_settings.svh"

package afu_pkg;

    // One host memory request, write data is ignored for reads
    typedef struct packed {
        logic                       write;
        logic [`AFU_ADDR_WIDTH-1:0] addr;
        logic [`AFU_DATA_WIDTH-1:0] data;
    } mem_req_t;

    // MMIO strobes from the host, each a single cycle
    typedef struct packed {
        logic                            read;
        logic                            write;
        logic [`AFU_MMIO_ADDR_WIDTH-1:0] addr;
        logic [`AFU_DATA_WIDTH-1:0]      wdata;
    } mmio_req_t;

    typedef struct packed {
        logic                       start;
        logic [`AFU_ADDR_WIDTH-1:0] src;
        logic [`AFU_ADDR_WIDTH-1:0] dst;
        logic [`AFU_ADDR_WIDTH-1:0] count;
        logic [`AFU_DATA_WIDTH-1:0] addend;
    } kernel_ctrl_t;

    typedef struct packed {
        logic                       busy;
        logic                       done;
        logic [`AFU_ADDR_WIDTH-1:0] words_done;
    } kernel_status_t;

    // Word offsets on the MMIO port
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_CTRL     = 'd0;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_STATUS   = 'd1;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_SRC      = 'd2;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_DST      = 'd3;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_COUNT    = 'd4;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_ADDEND   = 'd5;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_DMA_ADDR = 'd6;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_DMA_DATA = 'd7;
    localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] REG_SCRATCH  = 'd8;

endpackage

`default_nettype wire

// ==== design/req_fifo.sv ====
// Synchronous request queue with a generic payload and an occupancy count
`timescale 1ns/1ps
`default_nettype none
`include "afu_settings.svh"

module req_fifo #(
    parameter type payload_t = logic
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire payload_t                push_data,
    input  wire                          pop,
    output payload_t                     head,
    output logic                         empty,
    output logic                         full,
    output logic [`AFU_COUNT_WIDTH-1:0]  count
);

    localparam int PTR_WIDTH = $clog2(`AFU_FIFO_DEPTH);

    payload_t               mem [`AFU_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == `AFU_FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == `AFU_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == `AFU_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/mmio_csr.sv ====
// MMIO register block: kernel control, status readback, scratch register
// and the DMA write path with its sticky overflow flag
`timescale 1ns/1ps
`default_nettype none
`include "afu_settings.svh"

module mmio_csr (
    input  wire                              clk,
    input  wire                              rst,
    input  wire afu_pkg::mmio_req_t          mmio,
    output logic [`AFU_DATA_WIDTH-1:0]       mmio_readdata,
    output logic                             mmio_readdatavalid,
    output afu_pkg::kernel_ctrl_t            kernel_ctrl,
    input  wire afu_pkg::kernel_status_t     kernel_status,
    output logic                             dma_push,
    output afu_pkg::mem_req_t                dma_req,
    input  wire                              dma_full
);

    logic [`AFU_ADDR_WIDTH-1:0] src_addr;
    logic [`AFU_ADDR_WIDTH-1:0] dst_addr;
    logic [`AFU_ADDR_WIDTH-1:0] word_count;
    logic [`AFU_ADDR_WIDTH-1:0] dma_addr;
    logic [`AFU_DATA_WIDTH-1:0] addend;
    logic [`AFU_DATA_WIDTH-1:0] scratch;
    logic [`AFU_DATA_WIDTH-1:0] rd_value;
    logic                       start_pulse;
    logic                       dma_overflow;
    logic                       dma_hit;

    // A data write streams out at the current DMA address
    assign dma_hit  = mmio.write && (mmio.addr == afu_pkg::REG_DMA_DATA);
    assign dma_push = dma_hit && !dma_full;

    always_comb begin
        dma_req.write = 1'b1;
        dma_req.addr  = dma_addr;
        dma_req.data  = mmio.wdata;
    end

    always_comb begin
        kernel_ctrl.start  = start_pulse;
        kernel_ctrl.src    = src_addr;
        kernel_ctrl.dst    = dst_addr;
        kernel_ctrl.count  = word_count;
        kernel_ctrl.addend = addend;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_pulse  <= 1'b0;
            src_addr     <= '0;
            dst_addr     <= '0;
            word_count   <= '0;
            addend       <= '0;
            dma_addr     <= '0;
            scratch      <= '0;
            dma_overflow <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            if (mmio.write) begin
                case (mmio.addr)
                    afu_pkg::REG_CTRL:     start_pulse <= mmio.wdata[0];
                    afu_pkg::REG_SRC:      src_addr    <= mmio.wdata[`AFU_ADDR_WIDTH-1:0];
                    afu_pkg::REG_DST:      dst_addr    <= mmio.wdata[`AFU_ADDR_WIDTH-1:0];
                    afu_pkg::REG_COUNT:    word_count  <= mmio.wdata[`AFU_ADDR_WIDTH-1:0];
                    afu_pkg::REG_ADDEND:   addend      <= mmio.wdata;
                    afu_pkg::REG_DMA_ADDR: dma_addr    <= mmio.wdata[`AFU_ADDR_WIDTH-1:0];
                    afu_pkg::REG_SCRATCH:  scratch     <= mmio.wdata;
                    default: ;
                endcase
            end
            // Address moves on only for words that made it into the queue
            if (dma_push) begin
                dma_addr <= dma_addr + 1'b1;
            end else if (dma_hit) begin
                dma_overflow <= 1'b1;
            end
        end
    end

    // Status layout: busy [0], done [1], overflow [2], words done from bit 16
    always_comb begin
        rd_value = '0;
        case (mmio.addr)
            afu_pkg::REG_STATUS: begin
                rd_value[0] = kernel_status.busy;
                rd_value[1] = kernel_status.done;
                rd_value[2] = dma_overflow;
                rd_value[16 +: `AFU_ADDR_WIDTH] = kernel_status.words_done;
            end
            afu_pkg::REG_SRC:      rd_value[`AFU_ADDR_WIDTH-1:0] = src_addr;
            afu_pkg::REG_DST:      rd_value[`AFU_ADDR_WIDTH-1:0] = dst_addr;
            afu_pkg::REG_COUNT:    rd_value[`AFU_ADDR_WIDTH-1:0] = word_count;
            afu_pkg::REG_ADDEND:   rd_value = addend;
            afu_pkg::REG_DMA_ADDR: rd_value[`AFU_ADDR_WIDTH-1:0] = dma_addr;
            afu_pkg::REG_SCRATCH:  rd_value = scratch;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mmio_readdatavalid <= 1'b0;
            mmio_readdata      <= '0;
        end else begin
            mmio_readdatavalid <= mmio.read;
            if (mmio.read) begin
                mmio_readdata <= rd_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/kernel_engine.sv ====
// Kernel that reads a block of host words, adds a constant to each one
// and writes the results to a destination range
`timescale 1ns/1ps
`default_nettype none
`include "afu_settings.svh"

module kernel_engine (
    input  wire                               clk,
    input  wire                               rst,
    input  wire afu_pkg::kernel_ctrl_t        kernel_ctrl,
    output afu_pkg::kernel_status_t           kernel_status,
    output logic                              push,
    output afu_pkg::mem_req_t                 push_req,
    input  wire [`AFU_COUNT_WIDTH-1:0]        queue_count,
    input  wire                               queue_empty,
    input  wire [`AFU_DATA_WIDTH-1:0]         host_readdata,
    input  wire                               host_readdatavalid
);

    logic                       busy;
    logic                       done;
    logic [`AFU_ADDR_WIDTH-1:0] src_ptr;
    logic [`AFU_ADDR_WIDTH-1:0] dst_ptr;
    logic [`AFU_ADDR_WIDTH-1:0] reads_left;
    logic [`AFU_ADDR_WIDTH-1:0] writes_left;
    logic [`AFU_ADDR_WIDTH-1:0] words_done;
    logic [`AFU_DATA_WIDTH-1:0] addend;
    logic [`AFU_READS_WIDTH-1:0] in_flight;
    logic                       slot_ok;
    logic                       read_push;
    logic                       resp_push;

    // Every read in flight keeps a queue slot in reserve for its result
    assign slot_ok = (queue_count + in_flight) < `AFU_FIFO_DEPTH;

    // A returning word always wins the push port
    assign resp_push = busy && host_readdatavalid;
    assign read_push = busy && (reads_left != '0) && !host_readdatavalid
                       && (in_flight < `AFU_MAX_READS) && slot_ok;
    assign push      = read_push || resp_push;

    always_comb begin
        push_req.write = resp_push;
        push_req.addr  = resp_push ? dst_ptr : src_ptr;
        push_req.data  = resp_push ? (host_readdata + addend) : '0;
    end

    always_comb begin
        kernel_status.busy       = busy;
        kernel_status.done       = done;
        kernel_status.words_done = words_done;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            src_ptr     <= '0;
            dst_ptr     <= '0;
            reads_left  <= '0;
            writes_left <= '0;
            words_done  <= '0;
            addend      <= '0;
        end else if (!busy && kernel_ctrl.start) begin
            busy        <= 1'b1;
            done        <= 1'b0;
            src_ptr     <= kernel_ctrl.src;
            dst_ptr     <= kernel_ctrl.dst;
            reads_left  <= kernel_ctrl.count;
            writes_left <= kernel_ctrl.count;
            words_done  <= '0;
            addend      <= kernel_ctrl.addend;
        end else if (busy) begin
            if (read_push) begin
                src_ptr    <= src_ptr + 1'b1;
                reads_left <= reads_left - 1'b1;
            end
            if (resp_push) begin
                dst_ptr     <= dst_ptr + 1'b1;
                writes_left <= writes_left - 1'b1;
                words_done  <= words_done + 1'b1;
            end
            // Finished once every result has left the queue
            if ((writes_left == '0) && queue_empty) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Reads issued but not yet answered
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else if (read_push) begin
            in_flight <= in_flight + 1'b1;
        end else if (resp_push) begin
            in_flight <= in_flight - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/host_mem_arbiter.sv ====
// Round-robin merge of the DMA and kernel queues onto the host memory port
// with an output register held steady under waitrequest
`timescale 1ns/1ps
`default_nettype none

module host_mem_arbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire afu_pkg::mem_req_t   dma_head,
    input  wire                      dma_empty,
    output logic                     dma_pop,
    input  wire afu_pkg::mem_req_t   kern_head,
    input  wire                      kern_empty,
    output logic                     kern_pop,
    output afu_pkg::mem_req_t        host_req,
    output logic                     host_valid,
    input  wire                      host_waitrequest
);

    logic can_load;
    logic last_kern;

    // Output register is free or hands its request over this cycle
    assign can_load = !host_valid || !host_waitrequest;

    always_comb begin
        dma_pop  = 1'b0;
        kern_pop = 1'b0;
        if (can_load) begin
            if (!dma_empty && !kern_empty) begin
                // Both waiting, so the side not served last goes first
                kern_pop = !last_kern;
                dma_pop  = last_kern;
            end else begin
                dma_pop  = !dma_empty;
                kern_pop = !kern_empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host_valid <= 1'b0;
            last_kern  <= 1'b0;
        end else if (can_load) begin
            host_valid <= dma_pop || kern_pop;
            if (kern_pop) begin
                last_kern <= 1'b1;
            end else if (dma_pop) begin
                last_kern <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dma_pop) begin
            host_req <= dma_head;
        end else if (kern_pop) begin
            host_req <= kern_head;
        end
    end

endmodule

`default_nettype wire

// ==== design/afu.sv ====
// Accelerator shell top level: CSR block, kernel, DMA and kernel request
// queues and the host memory arbiter
`timescale 1ns/1ps
`default_nettype none
`include "afu_settings.svh"

module afu (
    input  wire                          clk,
    input  wire                          rst,
    input  wire afu_pkg::mmio_req_t      mmio,
    output logic [`AFU_DATA_WIDTH-1:0]   mmio_readdata,
    output logic                         mmio_readdatavalid,
    output afu_pkg::mem_req_t            host_req,
    output logic                         host_valid,
    input  wire                          host_waitrequest,
    input  wire [`AFU_DATA_WIDTH-1:0]    host_readdata,
    input  wire                          host_readdatavalid
);

    afu_pkg::kernel_ctrl_t        kernel_ctrl;
    afu_pkg::kernel_status_t      kernel_status;
    afu_pkg::mem_req_t            dma_req;
    afu_pkg::mem_req_t            dma_head;
    afu_pkg::mem_req_t            kern_req;
    afu_pkg::mem_req_t            kern_head;
    logic                         dma_push;
    logic                         dma_full;
    logic                         dma_empty;
    logic                         dma_pop;
    logic                         kern_push;
    logic                         kern_empty;
    logic                         kern_pop;
    logic [`AFU_COUNT_WIDTH-1:0]  kern_count;

    mmio_csr u_csr (
        .clk, .rst, .mmio, .mmio_readdata, .mmio_readdatavalid,
        .kernel_ctrl, .kernel_status, .dma_push, .dma_req, .dma_full
    );

    // Only the kernel issues reads, so responses go straight to it
    kernel_engine u_kernel (
        .clk, .rst, .kernel_ctrl, .kernel_status,
        .push(kern_push), .push_req(kern_req),
        .queue_count(kern_count), .queue_empty(kern_empty),
        .host_readdata, .host_readdatavalid
    );

    req_fifo #(.payload_t(afu_pkg::mem_req_t)) dma_q (
        .clk, .rst, .push(dma_push), .push_data(dma_req), .pop(dma_pop),
        .head(dma_head), .empty(dma_empty), .full(dma_full), .count()
    );

    req_fifo #(.payload_t(afu_pkg::mem_req_t)) kern_q (
        .clk, .rst, .push(kern_push), .push_data(kern_req), .pop(kern_pop),
        .head(kern_head), .empty(kern_empty), .full(), .count(kern_count)
    );

    host_mem_arbiter u_arb (
        .clk, .rst, .dma_head, .dma_empty, .dma_pop,
        .kern_head, .kern_empty, .kern_pop,
        .host_req, .host_valid, .host_waitrequest
    );

endmodule

`default_nettype wire

// ==== test/tb_afu.sv ====
// Table-driven testbench for the accelerator shell
// MMIO driver, host memory model with random waitrequest and read latency
`timescale 1ns/1ps
`default_nettype none
`include "afu_settings.svh"

module tb_afu;

    localparam int CLK_PERIOD = 100;

    localparam logic [2:0] OP_WRITE = 3'd0;
    localparam logic [2:0] OP_READ  = 3'd1;
    localparam logic [2:0] OP_POLL  = 3'd2;
    localparam logic [2:0] OP_MEM   = 3'd3;
    localparam logic [2:0] OP_MODE  = 3'd4;
    localparam logic [2:0] OP_IDLE  = 3'd5;
    localparam logic [2:0] OP_QUIET = 3'd6;

    // Kernel runs and DMA target ranges
    localparam logic [15:0] SRC_A = 16'h0100;
    localparam logic [15:0] DST_A = 16'h0400;
    localparam logic [15:0] CNT_A = 16'd16;
    localparam logic [63:0] ADD_A = 64'hF0E1_D2C3_B4A5_9687;
    localparam logic [15:0] SRC_B = 16'h0180;
    localparam logic [15:0] DST_B = 16'h0500;
    localparam logic [15:0] CNT_B = 16'd12;
    localparam logic [63:0] ADD_B = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam logic [15:0] DMA_A = 16'h0800;
    localparam logic [15:0] DMA_B = 16'h0900;
    localparam logic [15:0] DMA_C = 16'h0A00;

    // One table entry: operation, MMIO offset or host address, data, expected value
    typedef struct packed {
        logic [2:0]  op;
        logic [15:0] addr;
        logic [63:0] data;
        logic [63:0] exp_val;
    } step_t;

    logic                       clk = 1'b0;
    logic                       rst;
    afu_pkg::mmio_req_t         mmio;
    logic [`AFU_DATA_WIDTH-1:0] mmio_readdata;
    logic                       mmio_readdatavalid;
    afu_pkg::mem_req_t          host_req;
    logic                       host_valid;
    logic                       host_waitrequest = 1'b0;
    logic [`AFU_DATA_WIDTH-1:0] host_readdata = '0;
    logic                       host_readdatavalid = 1'b0;

    step_t       steps [$];
    bit          steps_ready = 1'b0;
    int          error_count = 0;
    int          check_count = 0;
    logic [1:0]  wr_mode = 2'd0;

    // Host memory model state
    logic [63:0] host_mem [0:65535];
    logic [31:0] rng = 32'd35433;
    int          cycle_cnt = 0;
    bit          mem_ready = 1'b0;
    int          fill_addr;
    logic        wreq;
    logic [15:0] rd_addr_q [$];
    int          rd_due_q [$];

    afu UUT (
        .clk, .rst, .mmio, .mmio_readdata, .mmio_readdatavalid,
        .host_req, .host_valid, .host_waitrequest, .host_readdata, .host_readdatavalid
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Initial memory contents, every field depends on the full address
    function automatic logic [63:0] fill_word(input logic [15:0] a);
        return {16'hF00D ^ a, a, ~a, a + 16'h1357};
    endfunction

    function automatic logic [63:0] dma_word(input int k);
        return 64'hD1A0_0000_0000_0000 | (64'(k) << 8) | 64'(k);
    endfunction

    // busy bit 0, done bit 1, overflow bit 2, words done from bit 16
    function automatic logic [63:0] status_word(input bit done, input bit ovf,
                                                input logic [15:0] words);
        return (64'(words) << 16) | (64'(ovf) << 2) | (64'(done) << 1);
    endfunction

    // Memory model: waitrequest, accepted requests and in-order read returns
    always @(negedge clk) begin
        if (!mem_ready) begin
            for (fill_addr = 0; fill_addr < 65536; fill_addr++) begin
                host_mem[fill_addr] = fill_word(16'(fill_addr));
            end
            mem_ready = 1'b1;
        end
        rng = xorshift32(rng);
        cycle_cnt = cycle_cnt + 1;
        case (wr_mode)
            2'd0:    wreq = 1'b0;
            2'd1:    wreq = (rng % 3) == 0;
            default: wreq = 1'b1;
        endcase
        host_waitrequest = wreq;
        // Request held now is taken at the next rising edge
        if (!rst && host_valid === 1'b1 && !wreq) begin
            if (host_req.write) begin
                host_mem[host_req.addr] = host_req.data;
            end else begin
                rd_addr_q.push_back(host_req.addr);
                rd_due_q.push_back(cycle_cnt + 1 + int'((rng >> 8) % 4));
            end
        end
        if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle_cnt) begin
            host_readdatavalid = 1'b1;
            host_readdata = host_mem[rd_addr_q.pop_front()];
            void'(rd_due_q.pop_front());
        end else begin
            host_readdatavalid = 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic add_step(input logic [2:0] op, input logic [15:0] addr,
                            input logic [63:0] data, input logic [63:0] exp_val);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.data = data;
        s.exp_val = exp_val;
        steps.push_back(s);
    endtask

    task automatic build_steps();
        int k;
        // Reset values and an idle host port
        add_step(OP_QUIET, 0, 4, 0);
        add_step(OP_READ, afu_pkg::REG_STATUS, 0, 0);
        add_step(OP_READ, afu_pkg::REG_CTRL, 0, 0);
        add_step(OP_READ, afu_pkg::REG_SCRATCH, 0, 0);
        add_step(OP_QUIET, 0, 4, 0);
        // Register readback and unused offsets
        add_step(OP_WRITE, afu_pkg::REG_SRC, SRC_A, 0);
        add_step(OP_WRITE, afu_pkg::REG_DST, DST_A, 0);
        add_step(OP_WRITE, afu_pkg::REG_COUNT, CNT_A, 0);
        add_step(OP_WRITE, afu_pkg::REG_ADDEND, ADD_A, 0);
        add_step(OP_WRITE, afu_pkg::REG_SCRATCH, 64'h0123_4567_89AB_CDEF, 0);
        add_step(OP_READ, afu_pkg::REG_SRC, 0, SRC_A);
        add_step(OP_READ, afu_pkg::REG_DST, 0, DST_A);
        add_step(OP_READ, afu_pkg::REG_COUNT, 0, CNT_A);
        add_step(OP_READ, afu_pkg::REG_ADDEND, 0, ADD_A);
        add_step(OP_READ, afu_pkg::REG_SCRATCH, 0, 64'h0123_4567_89AB_CDEF);
        add_step(OP_READ, 9, 0, 0);
        add_step(OP_READ, 15, 0, 0);
        add_step(OP_READ, afu_pkg::REG_DMA_DATA, 0, 0);
        // Three streamed DMA words under random waitrequest
        add_step(OP_MODE, 0, 1, 0);
        add_step(OP_WRITE, afu_pkg::REG_DMA_ADDR, DMA_A, 0);
        for (k = 0; k < 3; k++) begin
            add_step(OP_WRITE, afu_pkg::REG_DMA_DATA, dma_word(k), 0);
        end
        add_step(OP_READ, afu_pkg::REG_DMA_ADDR, 0, DMA_A + 3);
        for (k = 0; k < 3; k++) begin
            add_step(OP_MEM, DMA_A + 16'(k), 0, dma_word(k));
        end
        // Kernel run A with the registers set above
        add_step(OP_WRITE, afu_pkg::REG_CTRL, 1, 0);
        add_step(OP_POLL, 0, 0, status_word(1'b1, 1'b0, CNT_A));
        for (k = 0; k < CNT_A; k++) begin
            add_step(OP_MEM, DST_A + 16'(k), 0, fill_word(SRC_A + 16'(k)) + ADD_A);
        end
        add_step(OP_MEM, DST_A + CNT_A, 0, fill_word(DST_A + CNT_A));
        // Kernel run B with paced DMA writes alongside
        add_step(OP_WRITE, afu_pkg::REG_SRC, SRC_B, 0);
        add_step(OP_WRITE, afu_pkg::REG_DST, DST_B, 0);
        add_step(OP_WRITE, afu_pkg::REG_COUNT, CNT_B, 0);
        add_step(OP_WRITE, afu_pkg::REG_ADDEND, ADD_B, 0);
        add_step(OP_WRITE, afu_pkg::REG_DMA_ADDR, DMA_B, 0);
        add_step(OP_WRITE, afu_pkg::REG_CTRL, 1, 0);
        for (k = 0; k < 4; k++) begin
            add_step(OP_IDLE, 0, 5, 0);
            add_step(OP_WRITE, afu_pkg::REG_DMA_DATA, dma_word(10 + k), 0);
        end
        add_step(OP_POLL, 0, 0, status_word(1'b1, 1'b0, CNT_B));
        for (k = 0; k < CNT_B; k++) begin
            add_step(OP_MEM, DST_B + 16'(k), 0, fill_word(SRC_B + 16'(k)) + ADD_B);
        end
        for (k = 0; k < 4; k++) begin
            add_step(OP_MEM, DMA_B + 16'(k), 0, dma_word(10 + k));
        end
        // DMA overflow with the host port stalled
        add_step(OP_MODE, 0, 2, 0);
        add_step(OP_WRITE, afu_pkg::REG_DMA_ADDR, DMA_C, 0);
        for (k = 0; k < 10; k++) begin
            add_step(OP_WRITE, afu_pkg::REG_DMA_DATA, dma_word(100 + k), 0);
        end
        add_step(OP_READ, afu_pkg::REG_STATUS, 0, status_word(1'b1, 1'b1, CNT_B));
        add_step(OP_READ, afu_pkg::REG_DMA_ADDR, 0, DMA_C + `AFU_FIFO_DEPTH + 1);
        add_step(OP_MODE, 0, 0, 0);
        for (k = 0; k <= `AFU_FIFO_DEPTH; k++) begin
            add_step(OP_MEM, DMA_C + 16'(k), 0, dma_word(100 + k));
        end
        add_step(OP_MEM, DMA_C + `AFU_FIFO_DEPTH + 1, 0,
                 fill_word(DMA_C + `AFU_FIFO_DEPTH + 1));
    endtask

    task automatic mmio_write(input logic [7:0] offset, input logic [63:0] data);
        mmio.read = 1'b0;
        mmio.write = 1'b1;
        mmio.addr = offset;
        mmio.wdata = data;
        @(negedge clk);
        mmio = '0;
    endtask

    // Read data is due exactly one cycle after the strobe
    task automatic mmio_read(input logic [7:0] offset, output logic [63:0] data);
        mmio.read = 1'b1;
        mmio.write = 1'b0;
        mmio.addr = offset;
        mmio.wdata = '0;
        @(negedge clk);
        mmio = '0;
        check_value("mmio_readdatavalid", {63'd0, mmio_readdatavalid}, 64'd1);
        data = mmio_readdata;
    endtask

    task automatic wait_done(input logic [63:0] exp_status);
        logic [63:0] status;
        bit          finished;
        // Let the start pulse clear the done bit of the previous run
        repeat (2) @(negedge clk);
        finished = 1'b0;
        while (!finished) begin
            mmio_read(afu_pkg::REG_STATUS, status);
            finished = status[1] && !status[0];
        end
        check_value("kernel status", status, exp_status);
    endtask

    // Host port idle for a few cycles means nothing is left in flight
    task automatic wait_drain();
        int idle;
        idle = 0;
        while (idle < 3) begin
            @(negedge clk);
            if (host_valid === 1'b0) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
    endtask

    task automatic check_memory(input logic [15:0] addr, input logic [63:0] exp_val);
        wait_drain();
        check_value($sformatf("host_mem[%h]", addr), host_mem[addr], exp_val);
    endtask

    task automatic run_step(input step_t s);
        logic [63:0] rdata;
        case (s.op)
            OP_WRITE: mmio_write(s.addr[7:0], s.data);
            OP_READ: begin
                mmio_read(s.addr[7:0], rdata);
                check_value($sformatf("mmio_readdata[%0d]", s.addr), rdata, s.exp_val);
            end
            OP_POLL: wait_done(s.exp_val);
            OP_MEM: check_memory(s.addr, s.exp_val);
            OP_MODE: begin
                wr_mode = s.data[1:0];
                repeat (2) @(negedge clk);
            end
            OP_IDLE: repeat (s.data) @(negedge clk);
            OP_QUIET: begin
                repeat (s.data) begin
                    @(negedge clk);
                    check_value("host_valid", {63'd0, host_valid}, 64'd0);
                end
            end
            default: begin
                error_count++;
                $display("Unknown step operation %0d in the stimulus table", s.op);
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        mmio = '0;
        build_steps();
        steps_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        longint limit;
        wait (steps_ready);
        limit = longint'(steps.size()) * 200 * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d cycles", limit / CLK_PERIOD);
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== afu.f ====
+incdir+design
design/afu_pkg.sv
design/req_fifo.sv
design/mmio_csr.sv
design/kernel_engine.sv
design/host_mem_arbiter.sv
design/afu.sv
test/tb_afu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result
rm -rf obj_dir sim.log
verilator --binary --timing -f afu.f --top-module tb_afu -o tb_afu \
    && ./obj_dir/tb_afu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
